//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := cache_tb
FILELIST := filelist.f
BUILD    := obj_dir
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$($(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- dv/cache_tb.sv
module cache_tb import cache_pkg::*; ();

    localparam int          NUM_OPS    = 2000;
    localparam int          WORST_MISS = 60;   // write-back, refill and random gaps
    localparam int          MAX_CYCLES = NUM_OPS * WORST_MISS + 200;
    localparam logic [31:0] SEED       = 32'h2d9eba63;

    typedef struct packed {
        logic  op;
        addr_t addr;
        word_t exp;
    } pend_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_rd_req_t rd;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    mem_wr_req_t wr;
    logic        wr_rdy;

    word_t ref_mem [addr_t];      // words changed by stores
    bit    dirty_lines [addr_t];  // lines stored to since their last write-back
    pend_t pend [$];
    int    issued     = 0;
    int    cycles     = 0;
    int    value_errs = 0;
    int    proto_errs = 0;
    logic  accepted   = 1'b0;
    logic  last_store = 1'b0;
    addr_t last_addr  = '0;
    addr_t acc_line   = '0;       // line of the newest accepted request

    cache_top DUT (.*);
    mem_slave u_mem (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d responses still pending",
                     MAX_CYCLES, pend.size());
            $display("Test failures found");
            $finish;
        end
    end

    function automatic word_t ref_word(addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : a * 32'h9e37_79b9 + 32'h7f4a_7c15;
    endfunction

    function automatic line_t ref_line(addr_t a);
        line_t l;
        for (int b = 0; b < NUM_BANKS; b++) begin
            l[b*32 +: 32] = ref_word(a + addr_t'(b * 4));
        end
        return l;
    endfunction

    function automatic word_t apply_strobes(word_t old_w, word_t new_w, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(string name, line_t exp, line_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_type(string name, mem_type_t exp, mem_type_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_strb(string name, strb_t exp, strb_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic flag_protocol(string msg);
        proto_errs++;
        $display("protocol error at cycle %0d: %s", cycles, msg);
    endtask

    // few tags and indices so sets fill up and evict
    task automatic pick_request();
        tag_t   tag;
        index_t index;
        bank_t  bank;
        addr_t  a;
        logic   op;
        tag   = tag_t'(32'h4a310 + ($urandom % 4) * 32'h105);
        index = index_t'(($urandom % 3) * 83);
        bank  = bank_t'($urandom % 4);
        a     = {tag, index, bank, 2'b00};
        op    = ($urandom % 2) == 1;
        if (last_store && $urandom % 3 == 0) begin
            a  = last_addr;   // read back the word just stored
            op = 1'b0;
        end
        req.op     = op;
        req.tag    = a[31:12];
        req.index  = a[11:4];
        req.offset = a[3:0];
        req.wstrb  = op ? strb_t'($urandom % 15 + 1) : '0;
        req.wdata  = $urandom;
        last_store = op;
        last_addr  = a;
    endtask

    task automatic watch_outputs();
        pend_t p;
        addr_t line_a;
        if (data_ok) begin
            if (pend.size() == 0) begin
                flag_protocol("data_ok with no request pending");
            end else begin
                p = pend.pop_front();
                if (!p.op) begin
                    check_word($sformatf("load %h", p.addr), p.exp, rdata);
                end
            end
        end
        if (rd_req && rd_rdy) begin
            check_type("refill request type", MEM_TYPE_LINE, rd.mem_type);
            check_addr("refill address", acc_line, rd.addr);  // the miss is the newest request
        end
        if (wr_req) begin
            line_a = {wr.addr[31:4], 4'b0000};
            if (!wr_rdy) begin
                flag_protocol("write-back issued while wr_rdy was low");
            end
            if (wr.addr[3:0] != 4'b0000) begin
                flag_protocol($sformatf("write-back address %h not line aligned", wr.addr));
            end
            if (dirty_lines.exists(line_a)) begin
                dirty_lines.delete(line_a);
            end else begin
                flag_protocol($sformatf("write-back of clean line %h", line_a));
            end
            check_type("write-back type", MEM_TYPE_LINE, wr.mem_type);
            check_strb("write-back strobes", 4'hf, wr.wstrb);
            check_line($sformatf("write-back %h", line_a), ref_line(line_a), wr.data);
        end
        accepted = valid && addr_ok;
        if (accepted) begin
            p.op     = req.op;
            p.addr   = {req.tag, req.index, req.offset};
            p.exp    = ref_word(p.addr);
            acc_line = {p.addr[31:4], 4'b0000};
            if (req.op) begin
                ref_mem[p.addr] = apply_strobes(p.exp, req.wdata, req.wstrb);
                dirty_lines[{p.addr[31:4], 4'b0000}] = 1'b1;
            end
            pend.push_back(p);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        while (issued < NUM_OPS || valid || pend.size() != 0) begin
            @(negedge clk);
            watch_outputs();
            @(posedge clk);
            #1;
            if (accepted || !valid) begin
                valid = 1'b0;
                if (issued < NUM_OPS && $urandom % 4 != 0) begin
                    pick_request();
                    valid = 1'b1;
                    issued++;
                end
            end
        end
        repeat (8) begin   // catch stray responses
            @(negedge clk);
            watch_outputs();
        end
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dv/mem_slave.sv
module mem_slave import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  mem_rd_req_t rd,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output word_t       ret_data,
    input  logic        wr_req,
    input  mem_wr_req_t wr,
    output logic        wr_rdy
);

    line_t lines [addr_t];   // written lines by line address
    line_t cur_line;
    bank_t beat;
    logic  busy;
    logic  rd_take;
    logic  beat_taken;
    logic  last_taken;
    logic  in_reset;

    // initial contents hash the full word address
    function automatic word_t fill_word(addr_t a);
        return a * 32'h9e37_79b9 + 32'h7f4a_7c15;
    endfunction

    function automatic line_t read_line(addr_t a);
        line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            l[b*32 +: 32] = fill_word(a + addr_t'(b * 4));
        end
        return l;
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        busy      = 1'b0;
        beat      = '0;
        cur_line  = '0;
        forever begin
            @(negedge clk);
            in_reset   = !resetn;
            rd_take    = rd_req && rd_rdy;
            beat_taken = ret_valid;
            last_taken = ret_valid && ret_last;
            if (rd_take) begin
                cur_line = read_line({rd.addr[31:4], 4'b0000});
            end
            if (wr_req && wr_rdy) begin
                lines[{wr.addr[31:4], 4'b0000}] = wr.data;
            end
            @(posedge clk);
            #1;
            if (in_reset) begin
                busy      = 1'b0;
                rd_rdy    = 1'b0;
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                wr_rdy    = 1'b0;
            end else begin
                if (beat_taken) begin
                    beat = beat + 1'b1;   // wraps to 0 after the last beat
                    busy = !last_taken;
                end
                if (rd_take) begin
                    busy = 1'b1;
                    beat = '0;
                end
                ret_valid = busy && ($urandom % 4 != 0);
                ret_last  = ret_valid && beat == 2'd3;
                ret_data  = ret_valid ? cur_line[beat*32 +: 32] : '0;
                rd_rdy    = !busy && ($urandom % 3 != 0);  // one read at a time
                wr_rdy    = ($urandom % 4 != 0);
            end
        end
    end

endmodule

//--- filelist.f
hw/cache_pkg.sv
hw/sync_ram.sv
hw/cache_write_buffer.sv
hw/cache_meta.sv
hw/cache_ctrl.sv
hw/cache_top.sv
dv/mem_slave.sv
dv/cache_tb.sv

//--- hw/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; (
    input  logic                                  clk,
    input  logic                                  resetn,
    // cpu side
    input  logic                                  valid,
    input  cpu_req_t                              req,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output word_t                                 rdata,
    // memory read channel
    output logic                                  rd_req,
    output mem_rd_req_t                           rd,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  logic                                  ret_last,
    input  word_t                                 ret_data,
    // memory write channel
    output logic                                  wr_req,
    output mem_wr_req_t                           wr,
    input  logic                                  wr_rdy,
    // tag and data arrays
    output logic  [NUM_WAYS-1:0]                  tagv_we,
    output index_t                                tagv_addr,
    output tagv_t                                 tagv_wdata,
    input  tagv_t [NUM_WAYS-1:0]                  tagv_rdata,
    output strb_t [NUM_WAYS-1:0][NUM_BANKS-1:0]   bank_we,
    output index_t                                bank_addr,
    output word_t [NUM_BANKS-1:0]                 bank_wdata,
    input  word_t [NUM_WAYS-1:0][NUM_BANKS-1:0]   bank_rdata,
    // write buffer
    output logic                                  wb_push,
    output wbuf_entry_t                           wb_entry_in,
    input  logic                                  wb_conflict,
    input  logic                                  wb_commit,
    input  wbuf_entry_t                           wb_entry,
    // metadata
    output logic                                  hit_valid,
    output way_t                                  hit_way,
    output logic                                  refill_done,
    output logic                                  refill_dirty,
    input  way_t                                  victim_way,
    input  logic                                  victim_dirty
);

    cache_state_t        state, state_nxt;
    cpu_req_t            req_q;
    bank_t               bank_q;
    bank_t               ret_cnt;
    logic [NUM_SETS-1:0] line_valid [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q;      // lines aligned with the tag read
    logic [NUM_WAYS-1:0] hit_vec;
    logic                cache_hit;
    logic                lookup;
    logic                use_req_idx;
    logic                victim_valid;
    logic                victim_rd_ok;
    logic                refill_beat;
    tagv_t               victim_tagv;

    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        for (int i = 0; i < 4; i++) begin
            res[i*8 +: 8] = strb[i] ? new_w[i*8 +: 8] : old_w[i*8 +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (valid && addr_ok) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (cache_hit) begin
                    state_nxt = (valid && addr_ok) ? ST_LOOKUP : ST_IDLE;
                end else if (victim_valid && victim_dirty) begin
                    state_nxt = ST_MISS;
                end else begin
                    state_nxt = ST_REPLACE;
                end
            end
            ST_MISS:    if (wr_req) state_nxt = ST_REPLACE;
            ST_REPLACE: if (rd_rdy) state_nxt = ST_REFILL;
            ST_REFILL:  if (refill_done) state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_q <= req;
        end
    end
    assign bank_q = req_q.offset[3:2];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ret_cnt      <= '0;
            victim_rd_ok <= 1'b0;
            valid_q      <= '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                line_valid[w] <= '0;
            end
        end else begin
            if (refill_beat) begin
                ret_cnt <= ret_last ? bank_t'(0) : ret_cnt + 1'b1;
            end
            victim_rd_ok <= (state == ST_MISS);  // first miss cycle may see stale data
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= line_valid[w][tagv_addr];
                if (tagv_we[w]) begin
                    line_valid[w][req_q.index] <= 1'b1;
                end
            end
        end
    end

    // hit detection
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && tagv_rdata[w].valid && tagv_rdata[w].tag == req_q.tag;
        end
    end
    assign lookup       = (state == ST_LOOKUP);
    assign cache_hit    = |hit_vec;
    assign hit_way      = hit_vec[1];
    assign hit_valid    = lookup && cache_hit;
    assign victim_tagv  = tagv_rdata[victim_way];
    assign victim_valid = valid_q[victim_way] && victim_tagv.valid;

    // store hits go through the write buffer
    assign wb_push     = hit_valid && req_q.op;
    assign wb_entry_in = '{way: hit_way, index: req_q.index, bank: bank_q,
                           wstrb: req_q.wstrb, wdata: req_q.wdata};

    // a commit takes the data banks for one cycle
    assign use_req_idx = (state == ST_IDLE) || (lookup && cache_hit);
    assign tagv_addr   = use_req_idx ? req.index : req_q.index;
    assign bank_addr   = wb_commit ? wb_entry.index : tagv_addr;
    assign tagv_wdata  = '{tag: req_q.tag, valid: 1'b1};

    assign refill_beat  = (state == ST_REFILL) && ret_valid;
    assign refill_done  = refill_beat && ret_last;
    assign refill_dirty = req_q.op;  // store miss merged into the line

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_we[w][b] = '0;
                if (wb_commit && wb_entry.way == way_t'(w) && wb_entry.bank == bank_t'(b)) begin
                    bank_we[w][b] = wb_entry.wstrb;
                end else if (refill_beat && victim_way == way_t'(w) && ret_cnt == bank_t'(b)) begin
                    bank_we[w][b] = '1;
                end
            end
            tagv_we[w] = refill_done && victim_way == way_t'(w);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (wb_commit) begin
                bank_wdata[b] = wb_entry.wdata;
            end else if (req_q.op && bank_q == bank_t'(b)) begin
                bank_wdata[b] = merge_word(ret_data, req_q.wdata, req_q.wstrb);
            end else begin
                bank_wdata[b] = ret_data;
            end
        end
    end

    // cpu handshake
    assign addr_ok = use_req_idx && !wb_conflict &&
                     !(wb_commit && wb_entry.index != req.index);
    assign data_ok = (lookup && (cache_hit || req_q.op)) ||
                     (refill_beat && !req_q.op && ret_cnt == bank_q);  // critical word
    assign rdata   = (state == ST_REFILL) ? ret_data : bank_rdata[hit_way][bank_q];

    // memory channels
    assign rd_req = (state == ST_REPLACE);
    assign rd     = '{mem_type: MEM_TYPE_LINE, addr: {req_q.tag, req_q.index, 4'b0000}};

    assign wr_req = (state == ST_MISS) && victim_rd_ok && wr_rdy;
    assign wr     = '{mem_type: MEM_TYPE_LINE,
                      addr: {victim_tagv.tag, req_q.index, 4'b0000},
                      wstrb: 4'hf,
                      data: bank_rdata[victim_way]};

endmodule

//--- hw/cache_meta.sv
module cache_meta import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  index_t      index,
    input  logic        hit_valid,
    input  way_t        hit_way,
    input  logic        refill_done,
    input  logic        refill_dirty,
    input  logic        commit,
    input  wbuf_entry_t commit_entry,
    output way_t        victim_way,
    output logic        victim_dirty
);

    logic [NUM_SETS-1:0] dirty [NUM_WAYS];
    logic [NUM_SETS-1:0] repl;        // points at the next way to replace
    index_t              hit_index;   // set of the request in lookup
    logic                commit_hit;

    // index already moves on to the next request during a hit
    always_ff @(posedge clk) begin
        hit_index <= index;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                dirty[w] <= '0;
            end
            repl <= '0;
        end else begin
            if (commit) begin
                dirty[commit_entry.way][commit_entry.index] <= 1'b1;
            end
            if (refill_done) begin
                dirty[victim_way][index] <= refill_dirty;
            end
            if (hit_valid) begin
                repl[hit_index] <= ~hit_way;
            end else if (refill_done) begin
                repl[index] <= ~repl[index];
            end
        end
    end

    assign victim_way = repl[index];

    // a store landing this cycle already makes the victim dirty
    assign commit_hit   = commit && commit_entry.way == victim_way &&
                          commit_entry.index == index;
    assign victim_dirty = dirty[victim_way][index] || commit_hit;

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;   // words per line
    localparam int NUM_WAYS  = 2;
    localparam int TAGV_W    = 21;

    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;  // [3:2] picks the bank
    typedef logic [1:0]   bank_t;
    typedef logic         way_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;
    typedef logic [31:0]  addr_t;
    typedef logic [2:0]   mem_type_t;

    localparam mem_type_t MEM_TYPE_LINE = 3'b100;

    typedef struct packed {
        logic    op;       // 1 = store
        index_t  index;
        tag_t    tag;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        way_t   way;
        index_t index;
        bank_t  bank;
        strb_t  wstrb;
        word_t  wdata;
    } wbuf_entry_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    typedef struct packed {
        mem_type_t mem_type;
        addr_t     addr;
    } mem_rd_req_t;

    typedef struct packed {
        mem_type_t mem_type;
        addr_t     addr;
        strb_t     wstrb;
        line_t     data;
    } mem_wr_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REPLACE,
        ST_REFILL
    } cache_state_t;

    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wbuf_state_t;

endpackage

//--- hw/cache_top.sv
module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // cpu side
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    // memory read channel
    output logic        rd_req,
    output mem_rd_req_t rd,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    // memory write channel
    output logic        wr_req,
    output mem_wr_req_t wr,
    input  logic        wr_rdy
);

    logic  [NUM_WAYS-1:0]                tagv_we;
    index_t                              tagv_addr;
    tagv_t                               tagv_wdata;
    tagv_t [NUM_WAYS-1:0]                tagv_rdata;
    strb_t [NUM_WAYS-1:0][NUM_BANKS-1:0] bank_we;
    index_t                              bank_addr;
    word_t [NUM_BANKS-1:0]               bank_wdata;
    word_t [NUM_WAYS-1:0][NUM_BANKS-1:0] bank_rdata;

    logic        wb_push;
    wbuf_entry_t wb_entry_in;
    logic        wb_conflict;
    logic        wb_commit;
    wbuf_entry_t wb_entry;

    logic hit_valid;
    way_t hit_way;
    logic refill_done;
    logic refill_dirty;
    way_t victim_way;
    logic victim_dirty;

    cache_ctrl u_ctrl (.*);

    cache_write_buffer u_wbuf (
        .clk        (clk),
        .resetn     (resetn),
        .push       (wb_push),
        .push_entry (wb_entry_in),
        .req_valid  (valid),
        .req        (req),
        .conflict   (wb_conflict),
        .commit     (wb_commit),
        .entry      (wb_entry)
    );

    cache_meta u_meta (
        .clk          (clk),
        .resetn       (resetn),
        .index        (tagv_addr),
        .hit_valid    (hit_valid),
        .hit_way      (hit_way),
        .refill_done  (refill_done),
        .refill_dirty (refill_dirty),
        .commit       (wb_commit),
        .commit_entry (wb_entry),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        sync_ram #(.WIDTH(TAGV_W), .DEPTH(NUM_SETS), .LANES(1)) u_tagv (
            .clk   (clk),
            .we    (tagv_we[w]),
            .addr  (tagv_addr),
            .wdata (tagv_wdata),
            .rdata (tagv_rdata[w])
        );
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            sync_ram #(.WIDTH(32), .DEPTH(NUM_SETS), .LANES(4)) u_bank (
                .clk   (clk),
                .we    (bank_we[w][b]),
                .addr  (bank_addr),
                .wdata (bank_wdata[b]),
                .rdata (bank_rdata[w][b])
            );
        end
    end

endmodule

//--- hw/cache_write_buffer.sv
module cache_write_buffer import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        push,
    input  wbuf_entry_t push_entry,
    input  logic        req_valid,
    input  cpu_req_t    req,
    output logic        conflict,
    output logic        commit,
    output wbuf_entry_t entry
);

    wbuf_state_t state, state_nxt;
    wbuf_entry_t entry_q;
    logic        push_match;
    logic        pend_match;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            WB_IDLE:  state_nxt = push ? WB_WRITE : WB_IDLE;
            WB_WRITE: state_nxt = push ? WB_WRITE : WB_IDLE;  // back to back stores
            default:  state_nxt = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q <= push_entry;
        end
    end

    assign commit = (state == WB_WRITE);
    assign entry  = entry_q;

    // load would read a word that is not in the RAM yet
    assign push_match = push && push_entry.index == req.index &&
                        push_entry.bank == req.offset[3:2];
    assign pend_match = commit && entry_q.index == req.index &&
                        entry_q.bank == req.offset[3:2];
    assign conflict   = req_valid && !req.op && (push_match || pend_match);

endmodule

//--- hw/sync_ram.sv
module sync_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256,
    parameter int LANES = 4
) (
    input  logic                     clk,
    input  logic [LANES-1:0]         we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    localparam int LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];

    // lane writes
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we[l]) begin
                mem[addr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
            end
        end
    end

    // registered read returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule
